//--- design/rtp_macros.svh
`ifndef RTP_MACROS_SVH
`define RTP_MACROS_SVH

// stream geometry
`define RTP_DATA_W          64
`define RTP_KEEP_W          8

// camera channels, tdest selects one of them
`define RTP_NUM_CH          4
`define RTP_CH_W            2

// frame geometry, kept small for simulation
`define RTP_LINES_PER_FRAME 4
`define RTP_LINE_BYTES      64

// rtp field values
`define RTP_PAYLOAD_TYPE    96
`define RTP_VERSION         2
// 90 kHz clock at 30 frames per second
`define RTP_TS_STEP         3000
`define RTP_SSRC_BASE       32'h5A5A0000

`endif

//--- design/rtp_pkg.sv
`include "rtp_macros.svh"

package rtp_pkg;

  // ****************************************
  // rtp fixed header, 12 bytes
  // ****************************************
  typedef struct packed {
    logic [1:0]  version;
    logic        padding;
    logic        extension;
    logic [3:0]  csrc_count;
    logic        marker;
    logic [6:0]  payload_type;
    logic [15:0] seq_num;
    logic [31:0] timestamp;
    logic [31:0] ssrc;
  } rtp_header_t;

  // ****************************************
  // payload header, 8 bytes, one line per packet
  // ****************************************
  typedef struct packed {
    logic [15:0] ext_seq_num;
    logic [15:0] length;
    logic        field_id;
    logic [14:0] line_num;
    logic        cont;
    logic [14:0] offset;
  } rtp_pd_header_t;

  // one axi-stream beat
  typedef struct packed {
    logic [`RTP_DATA_W-1:0] data;
    logic [`RTP_KEEP_W-1:0] keep;
    logic                   last;
  } axis_beat_t;

  // packetizer states, one per header beat
  typedef enum logic [2:0] {
    IDLE,
    HDR_RTP,
    HDR_SSRC,
    HDR_LINE,
    PAYLOAD
  } pkt_state_t;

endpackage

//--- design/rtp_stream_demux.sv
`timescale 1ns/1ps
`include "rtp_macros.svh"

module rtp_stream_demux (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  rtp_pkg::axis_beat_t       s_beat,
  input  logic [`RTP_CH_W-1:0]      s_dest,
  input  logic                      s_valid,
  output logic                      s_ready,
  output rtp_pkg::axis_beat_t       ch_beat [`RTP_NUM_CH],
  output logic [`RTP_NUM_CH-1:0]    ch_valid,
  input  logic [`RTP_NUM_CH-1:0]    ch_ready
);

  logic                 locked;
  logic [`RTP_CH_W-1:0] sel_q;
  logic [`RTP_CH_W-1:0] sel;
  logic                 xfer;

  // tdest counts only on the first beat, later beats follow the lock
  assign sel  = locked ? sel_q : s_dest;
  assign xfer = s_valid && s_ready;

  // ready comes back from whichever packetizer is selected
  assign s_ready = ch_ready[sel];

  always_comb begin
    for (int i = 0; i < `RTP_NUM_CH; i++) begin
      ch_beat[i]  = s_beat;
      ch_valid[i] = s_valid && (sel == i);
    end
  end

  // lock on the first transferred beat, release on the transferred last
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      locked <= 1'b0;
      sel_q  <= '0;
    end else if (xfer) begin
      locked <= !s_beat.last;
      sel_q  <= sel;
    end
  end

endmodule

//--- design/rtp_packetizer.sv
`timescale 1ns/1ps
`include "rtp_macros.svh"

module rtp_packetizer #(
  parameter logic [31:0] ch_ssrc = `RTP_SSRC_BASE
) (
  input  logic                aclk,
  input  logic                aresetn,
  input  rtp_pkg::axis_beat_t in_beat,
  input  logic                in_valid,
  output logic                in_ready,
  output rtp_pkg::axis_beat_t out_beat,
  output logic                out_valid,
  input  logic                out_ready
);

  import rtp_pkg::*;

  // at least one bit even for a one-line frame
  localparam int LINE_W = ($clog2(`RTP_LINES_PER_FRAME) > 0) ?
                          $clog2(`RTP_LINES_PER_FRAME) : 1;
  localparam logic [LINE_W-1:0] LAST_LINE = LINE_W'(`RTP_LINES_PER_FRAME - 1);

  pkt_state_t     state_q;
  pkt_state_t     state_d;

  rtp_header_t    rtp_hdr;
  rtp_pd_header_t pd_hdr;

  // per-channel counters
  logic [15:0]       seq_num;
  logic [15:0]       ext_seq_num;
  logic [LINE_W-1:0] line_cnt;
  logic [31:0]       timestamp;
  logic              last_line;

  // one-beat payload register
  axis_beat_t pay_beat;
  logic       pay_valid;
  // set once the line's last beat has been taken in
  logic       last_taken;
  logic       in_xfer;
  logic       pkt_done;

  // ****************************************
  // header fields
  // ****************************************
  assign last_line = (line_cnt == LAST_LINE);

  always_comb begin
    rtp_hdr.version      = 2'(`RTP_VERSION);
    rtp_hdr.padding      = 1'b0;
    rtp_hdr.extension    = 1'b0;
    rtp_hdr.csrc_count   = 4'h0;
    // marker flags the last line of a progressive frame
    rtp_hdr.marker       = last_line;
    rtp_hdr.payload_type = 7'(`RTP_PAYLOAD_TYPE);
    rtp_hdr.seq_num      = seq_num;
    rtp_hdr.timestamp    = timestamp;
    rtp_hdr.ssrc         = ch_ssrc;

    pd_hdr.ext_seq_num   = ext_seq_num;
    pd_hdr.length        = 16'(`RTP_LINE_BYTES);
    // progressive scan, single line per packet
    pd_hdr.field_id      = 1'b0;
    pd_hdr.line_num      = 15'(line_cnt);
    pd_hdr.cont          = 1'b0;
    pd_hdr.offset        = 15'h0;
  end

  // ****************************************
  // state machine
  // ****************************************
  assign in_xfer  = in_valid && in_ready;
  assign pkt_done = (state_q == PAYLOAD) && pay_valid && out_ready && pay_beat.last;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (in_valid) begin
          state_d = HDR_RTP;
        end
      end
      HDR_RTP: begin
        if (out_ready) begin
          state_d = HDR_SSRC;
        end
      end
      HDR_SSRC: begin
        if (out_ready) begin
          state_d = HDR_LINE;
        end
      end
      HDR_LINE: begin
        if (out_ready) begin
          state_d = PAYLOAD;
        end
      end
      PAYLOAD: begin
        if (pkt_done) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ****************************************
  // payload path
  // ****************************************
  // input stalls during header beats and after the last beat is in
  assign in_ready = (state_q == PAYLOAD) && !last_taken && (!pay_valid || out_ready);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      pay_valid  <= 1'b0;
      last_taken <= 1'b0;
    end else begin
      if (in_xfer) begin
        pay_valid <= 1'b1;
      end else if (out_ready) begin
        pay_valid <= 1'b0;
      end
      if (pkt_done) begin
        last_taken <= 1'b0;
      end else if (in_xfer && in_beat.last) begin
        last_taken <= 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (in_xfer) begin
      pay_beat <= in_beat;
    end
  end

  // output mux, header beats come straight from the state
  always_comb begin
    out_beat  = pay_beat;
    out_valid = 1'b0;
    case (state_q)
      HDR_RTP: begin
        out_beat.data = rtp_hdr[95:32];
        out_beat.keep = 8'hFF;
        out_beat.last = 1'b0;
        out_valid     = 1'b1;
      end
      HDR_SSRC: begin
        // ssrc, then the first half of the payload header
        out_beat.data = {rtp_hdr.ssrc, pd_hdr.ext_seq_num, pd_hdr.length};
        out_beat.keep = 8'hFF;
        out_beat.last = 1'b0;
        out_valid     = 1'b1;
      end
      HDR_LINE: begin
        // line and offset words fill the upper 4 bytes only
        out_beat.data = {pd_hdr[31:0], 32'h0};
        out_beat.keep = 8'hF0;
        out_beat.last = 1'b0;
        out_valid     = 1'b1;
      end
      PAYLOAD: begin
        out_valid = pay_valid;
      end
      default: begin
        out_valid = 1'b0;
      end
    endcase
  end

  // ****************************************
  // counters, advanced as a packet leaves
  // ****************************************
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      seq_num     <= '0;
      ext_seq_num <= '0;
      line_cnt    <= '0;
      timestamp   <= '0;
    end else if (pkt_done) begin
      seq_num <= seq_num + 16'd1;
      // high half moves on when the low half wraps
      if (seq_num == 16'hFFFF) begin
        ext_seq_num <= ext_seq_num + 16'd1;
      end
      if (last_line) begin
        line_cnt  <= '0;
        // next frame gets a new timestamp
        timestamp <= timestamp + 32'(`RTP_TS_STEP);
      end else begin
        line_cnt <= line_cnt + 1'b1;
      end
    end
  end

endmodule

//--- design/rtp_packet_arbiter.sv
`timescale 1ns/1ps
`include "rtp_macros.svh"

module rtp_packet_arbiter (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  rtp_pkg::axis_beat_t    ch_beat [`RTP_NUM_CH],
  input  logic [`RTP_NUM_CH-1:0] ch_valid,
  output logic [`RTP_NUM_CH-1:0] ch_ready,
  output rtp_pkg::axis_beat_t    m_beat,
  output logic                   m_valid,
  input  logic                   m_ready
);

  import rtp_pkg::*;

  logic [`RTP_CH_W-1:0] grant_q;
  logic                 busy;
  logic [`RTP_CH_W-1:0] next_ch;
  logic                 next_found;
  logic                 take;

  // registered output stage
  axis_beat_t out_q;
  logic       out_valid_q;

  // ****************************************
  // round-robin pick
  // ****************************************
  // search starts one past the last granted channel
  always_comb begin
    int cand;
    next_ch    = grant_q;
    next_found = 1'b0;
    for (int i = 1; i <= `RTP_NUM_CH; i++) begin
      cand = (int'(grant_q) + i) % `RTP_NUM_CH;
      if (!next_found && ch_valid[cand]) begin
        next_ch    = `RTP_CH_W'(cand);
        next_found = 1'b1;
      end
    end
  end

  // only the granted channel sees ready
  always_comb begin
    for (int i = 0; i < `RTP_NUM_CH; i++) begin
      ch_ready[i] = busy && (grant_q == i) && (!out_valid_q || m_ready);
    end
  end

  assign take = busy && ch_valid[grant_q] && ch_ready[grant_q];

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      busy    <= 1'b0;
      // channel 0 wins first
      grant_q <= `RTP_CH_W'(`RTP_NUM_CH - 1);
    end else if (!busy) begin
      if (next_found) begin
        busy    <= 1'b1;
        grant_q <= next_ch;
      end
    end else if (take && ch_beat[grant_q].last) begin
      // packet fully taken, free the grant
      busy <= 1'b0;
    end
  end

  // ****************************************
  // output register
  // ****************************************
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      out_valid_q <= 1'b0;
    end else if (take) begin
      out_valid_q <= 1'b1;
    end else if (m_ready) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      out_q <= ch_beat[grant_q];
    end
  end

  assign m_beat  = out_q;
  assign m_valid = out_valid_q;

endmodule

//--- design/rtp_engine.sv
`timescale 1ns/1ps
`include "rtp_macros.svh"

module rtp_engine (
  input  logic                 aclk,
  input  logic                 aresetn,
  input  rtp_pkg::axis_beat_t  s_beat,
  input  logic [`RTP_CH_W-1:0] s_dest,
  input  logic                 s_valid,
  output logic                 s_ready,
  output rtp_pkg::axis_beat_t  m_beat,
  output logic                 m_valid,
  input  logic                 m_ready
);

  import rtp_pkg::*;

  // demux to packetizers
  axis_beat_t             ch_in_beat [`RTP_NUM_CH];
  logic [`RTP_NUM_CH-1:0] ch_in_valid;
  logic [`RTP_NUM_CH-1:0] ch_in_ready;

  // packetizers to arbiter
  axis_beat_t             ch_out_beat [`RTP_NUM_CH];
  logic [`RTP_NUM_CH-1:0] ch_out_valid;
  logic [`RTP_NUM_CH-1:0] ch_out_ready;

  rtp_stream_demux i_demux (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .s_beat   (s_beat),
    .s_dest   (s_dest),
    .s_valid  (s_valid),
    .s_ready  (s_ready),
    .ch_beat  (ch_in_beat),
    .ch_valid (ch_in_valid),
    .ch_ready (ch_in_ready)
  );

  // one packetizer per camera, each with its own ssrc
  for (genvar k = 0; k < `RTP_NUM_CH; k++) begin : g_ch
    rtp_packetizer #(
      .ch_ssrc (`RTP_SSRC_BASE + 32'(k))
    ) i_pkt (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .in_beat   (ch_in_beat[k]),
      .in_valid  (ch_in_valid[k]),
      .in_ready  (ch_in_ready[k]),
      .out_beat  (ch_out_beat[k]),
      .out_valid (ch_out_valid[k]),
      .out_ready (ch_out_ready[k])
    );
  end

  rtp_packet_arbiter i_arb (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .ch_beat  (ch_out_beat),
    .ch_valid (ch_out_valid),
    .ch_ready (ch_out_ready),
    .m_beat   (m_beat),
    .m_valid  (m_valid),
    .m_ready  (m_ready)
  );

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 2
) (
  output logic aclk,
  output logic aresetn
);

  // free running clock, starts low
  initial begin
    aclk = 1'b0;
    forever #(period_ns / 2) aclk = ~aclk;
  end

  // reset released just after the last reset edge
  initial begin
    aresetn = 1'b0;
    repeat (reset_cycles) @(posedge aclk);
    #2;
    aresetn = 1'b1;
  end

endmodule

//--- test/rtp_checker.sv
`timescale 1ns/1ps
`include "rtp_macros.svh"

module rtp_checker (
  input  logic                 aclk,
  input  logic                 aresetn,
  input  rtp_pkg::axis_beat_t  s_beat,
  input  logic [`RTP_CH_W-1:0] s_dest,
  input  logic                 s_valid,
  input  logic                 s_ready,
  input  rtp_pkg::axis_beat_t  m_beat,
  input  logic                 m_valid,
  input  logic                 m_ready,
  output int                   error_count,
  output int                   packet_count,
  output int                   line_count
);

  import rtp_pkg::*;

  // expected payload beats per channel, in input order
  axis_beat_t exp_q [`RTP_NUM_CH][$];

  // model of each packetizer's counters
  int unsigned seq_m  [`RTP_NUM_CH];
  int unsigned ext_m  [`RTP_NUM_CH];
  int unsigned line_m [`RTP_NUM_CH];
  int unsigned ts_m   [`RTP_NUM_CH];

  // input side
  logic                 in_line;
  logic [`RTP_CH_W-1:0] in_ch;
  logic                 seen_input;

  // output side
  int          beat_idx;
  int          out_ch;
  logic        pkt_bad;
  logic [63:0] hdr0;
  logic [31:0] ssrc_off;
  axis_beat_t  exp_beat;

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    $display("MISMATCH t=%0t %s expected=%0h actual=%0h", $time, name, exp_v, act_v);
    error_count++;
  endtask

  task automatic check_field(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      report_mismatch(name, exp_v, act_v);
    end
  endtask

  task automatic report_failure(input string what);
    $display("ERROR t=%0t %s", $time, what);
    error_count++;
  endtask

  // ****************************************
  // per-channel model update at packet end
  // ****************************************
  task automatic advance_model(input int ch);
    seq_m[ch] = (seq_m[ch] + 1) & 32'hFFFF;
    // extended number carries the wrap of the low half
    if (seq_m[ch] == 0) begin
      ext_m[ch] = (ext_m[ch] + 1) & 32'hFFFF;
    end
    if (line_m[ch] == `RTP_LINES_PER_FRAME - 1) begin
      line_m[ch] = 0;
      ts_m[ch]   = ts_m[ch] + `RTP_TS_STEP;
    end else begin
      line_m[ch] = line_m[ch] + 1;
    end
  endtask

  // sampled mid-cycle, each transfer completes on the following rising edge
  always @(negedge aclk) begin
    if (!aresetn) begin
      for (int i = 0; i < `RTP_NUM_CH; i++) begin
        exp_q[i].delete();
        seq_m[i]  = 0;
        ext_m[i]  = 0;
        line_m[i] = 0;
        ts_m[i]   = 0;
      end
      in_line      = 1'b0;
      in_ch        = '0;
      seen_input   = 1'b0;
      beat_idx     = 0;
      out_ch       = 0;
      pkt_bad      = 1'b0;
      error_count  = 0;
      packet_count = 0;
      line_count   = 0;
    end else begin
      // a line counts as driven once its first beat is offered
      if (s_valid) begin
        seen_input = 1'b1;
      end

      // nothing may come out before a line went in
      if (m_valid && !seen_input) begin
        report_failure("m_valid high before any line was driven");
      end

      if (m_valid && m_ready) begin
        if (beat_idx == 0) begin
          // fixed rtp fields, the rest waits for the ssrc
          hdr0 = m_beat.data;
          check_field("hdr0 version", `RTP_VERSION, hdr0[63:62]);
          check_field("hdr0 padding", 0, hdr0[61]);
          check_field("hdr0 extension", 0, hdr0[60]);
          check_field("hdr0 csrc_count", 0, hdr0[59:56]);
          check_field("hdr0 payload_type", `RTP_PAYLOAD_TYPE, hdr0[54:48]);
          check_field("hdr0 keep", 8'hFF, m_beat.keep);
          check_field("hdr0 last", 0, m_beat.last);
        end else if (beat_idx == 1) begin
          ssrc_off = m_beat.data[63:32] - `RTP_SSRC_BASE;
          if (ssrc_off >= `RTP_NUM_CH) begin
            report_failure($sformatf("packet with unknown SSRC %0h", m_beat.data[63:32]));
            pkt_bad = 1'b1;
          end else begin
            out_ch  = int'(ssrc_off);
            pkt_bad = 1'b0;
            // marker only on the frame's last line
            check_field($sformatf("ch%0d marker", out_ch),
                        line_m[out_ch] == `RTP_LINES_PER_FRAME - 1, hdr0[55]);
            check_field($sformatf("ch%0d seq_num", out_ch), seq_m[out_ch], hdr0[47:32]);
            check_field($sformatf("ch%0d timestamp", out_ch), ts_m[out_ch], hdr0[31:0]);
            check_field($sformatf("ch%0d ext_seq_num", out_ch), ext_m[out_ch],
                        m_beat.data[31:16]);
            check_field($sformatf("ch%0d length", out_ch), `RTP_LINE_BYTES,
                        m_beat.data[15:0]);
          end
          check_field("hdr1 keep", 8'hFF, m_beat.keep);
          check_field("hdr1 last", 0, m_beat.last);
        end else if (beat_idx == 2) begin
          if (!pkt_bad) begin
            check_field($sformatf("ch%0d field_id", out_ch), 0, m_beat.data[63]);
            check_field($sformatf("ch%0d line_num", out_ch), line_m[out_ch],
                        m_beat.data[62:48]);
          end
          // continuation and offset both zero, one line per packet
          check_field("hdr2 cont_offset", 0, m_beat.data[47:32]);
          check_field("hdr2 keep", 8'hF0, m_beat.keep);
          check_field("hdr2 last", 0, m_beat.last);
        end else if (!pkt_bad) begin
          if (exp_q[out_ch].size() == 0) begin
            report_failure($sformatf("payload beat on channel %0d with no line pending",
                                     out_ch));
          end else begin
            exp_beat = exp_q[out_ch].pop_front();
            check_field($sformatf("ch%0d payload data", out_ch), exp_beat.data,
                        m_beat.data);
            check_field($sformatf("ch%0d payload keep", out_ch), exp_beat.keep,
                        m_beat.keep);
            check_field($sformatf("ch%0d payload last", out_ch), exp_beat.last,
                        m_beat.last);
          end
        end

        if (m_beat.last) begin
          if (beat_idx < 3) begin
            report_failure("packet ended inside its header");
          end else if (!pkt_bad) begin
            advance_model(out_ch);
          end
          packet_count++;
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end

      // input lines, channel taken from tdest at the first beat
      if (s_valid && s_ready) begin
        if (!in_line) begin
          in_ch = s_dest;
        end
        exp_q[in_ch].push_back(s_beat);
        in_line = !s_beat.last;
        if (s_beat.last) begin
          line_count++;
        end
      end
    end
  end

endmodule

//--- test/rtp_engine_tb.sv
`timescale 1ns/1ps
`include "rtp_macros.svh"

module rtp_engine_tb;

  import rtp_pkg::*;

  localparam int     beats_per_line = `RTP_LINE_BYTES / 8;
  localparam int     total_lines    = 3 * `RTP_LINES_PER_FRAME * `RTP_NUM_CH;
  // every beat plus header beats, 40 ns each, with a wide margin
  localparam longint timeout_ns     = total_lines * (beats_per_line + 3) * 40 * 20;

  logic                 aclk;
  logic                 aresetn;
  axis_beat_t           s_beat;
  logic [`RTP_CH_W-1:0] s_dest;
  logic                 s_valid;
  logic                 s_ready;
  axis_beat_t           m_beat;
  logic                 m_valid;
  logic                 m_ready;

  int     error_count;
  int     packet_count;
  int     line_count;
  integer seed;
  int     line_order [total_lines];
  int     line_idx;
  int     beat_idx;
  logic   sent;

  tb_clock_gen clk0 (
    .aclk    (aclk),
    .aresetn (aresetn)
  );

  rtp_engine dut0 (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_beat  (s_beat),
    .s_dest  (s_dest),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_beat  (m_beat),
    .m_valid (m_valid),
    .m_ready (m_ready)
  );

  rtp_checker chk0 (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .s_beat       (s_beat),
    .s_dest       (s_dest),
    .s_valid      (s_valid),
    .s_ready      (s_ready),
    .m_beat       (m_beat),
    .m_valid      (m_valid),
    .m_ready      (m_ready),
    .error_count  (error_count),
    .packet_count (packet_count),
    .line_count   (line_count)
  );

  // ****************************************
  // stimulus
  // ****************************************
  // equal lines per channel, then a random interleave
  task automatic shuffle_lines();
    int j;
    int tmp;
    for (int i = 0; i < total_lines; i++) begin
      line_order[i] = i % `RTP_NUM_CH;
    end
    for (int i = total_lines - 1; i > 0; i--) begin
      j             = $unsigned($random(seed)) % (i + 1);
      tmp           = line_order[i];
      line_order[i] = line_order[j];
      line_order[j] = tmp;
    end
  endtask

  task automatic load_beat();
    s_dest      = `RTP_CH_W'(line_order[line_idx]);
    s_beat.data = {$random(seed), $random(seed)};
    s_beat.keep = 8'hFF;
    s_beat.last = (beat_idx == beats_per_line - 1);
  endtask

  initial begin
    seed     = 44859;
    s_beat   = '0;
    s_dest   = '0;
    s_valid  = 1'b0;
    m_ready  = 1'b0;
    line_idx = 0;
    beat_idx = 0;
    shuffle_lines();
    wait (aresetn);
    while (line_idx < total_lines || packet_count < total_lines) begin
      // handshake seen mid-cycle, taken on the next edge
      @(negedge aclk);
      sent = s_valid && s_ready;
      if (sent) begin
        beat_idx++;
        if (beat_idx == beats_per_line) begin
          beat_idx = 0;
          line_idx++;
        end
      end
      @(posedge aclk);
      #2;
      // back-pressure, ready about 70% of cycles
      m_ready = ($unsigned($random(seed)) % 10) < 7;
      // a raised valid holds until its beat is taken
      if (sent || !s_valid) begin
        if (line_idx < total_lines && ($unsigned($random(seed)) % 4) != 0) begin
          load_beat();
          s_valid = 1'b1;
        end else begin
          s_valid = 1'b0;
        end
      end
    end
    // a few idle cycles to catch stray output
    repeat (8) @(posedge aclk);
    $display("closing: %0d of %0d packets, %0d lines in, %0d errors",
             packet_count, total_lines, line_count, error_count);
    if (error_count == 0 && packet_count == total_lines && line_count == total_lines) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(timeout_ns);
    $display("timeout: %0d of %0d packets missing, %0d errors",
             total_lines - packet_count, total_lines, error_count);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- sim.f
+incdir+design
design/rtp_pkg.sv
design/rtp_stream_demux.sv
design/rtp_packetizer.sv
design/rtp_packet_arbiter.sv
design/rtp_engine.sv
test/tb_clock_gen.sv
test/rtp_checker.sv
test/rtp_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f sim.f --top-module rtp_engine_tb -o rtp_sim
./obj_dir/rtp_sim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
